// ==== tb.f ====
+incdir+source
source/mmu_pkg.sv
source/cache_pkg.sv
source/lookup_ram.sv
source/tlb_lookup.sv
source/line_lookup.sv
source/miss_ctrl.sv
source/mmu_cache_top.sv
sim/tb_clk_gen.sv
sim/mmu_cache_asserts.sv
sim/tb_mmu_cache.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the cache testbench with Verilator

cd "$(dirname "$0")" || exit 1

top=tb_mmu_cache
log=sim.log

verilator --binary --timing --assert --top-module "$top" -f tb.f -o "V$top" > build.log 2>&1
status=$?
if [ $status -ne 0 ]; then
  cat build.log
  echo "build failed with status $status"
  exit 1
fi

"./obj_dir/V$top" > "$log" 2>&1
status=$?
cat "$log"

if grep -q "tests failed" "$log"; then
  echo "simulation reported a failure"
  exit 1
fi
if [ $status -ne 0 ]; then
  echo "simulation stopped with status $status"
  exit 1
fi
echo "simulation finished cleanly"
exit 0

// ==== sim/tb_mmu_cache.sv ====
/* testbench top with a memory model of random read delay, directed tests
   of the TLB and cache paths, compare tasks and watchdog */
`timescale 1ns/1ps
`default_nettype none
`include "mmu_cache_consts.svh"

module tb_mmu_cache;
  import mmu_pkg::*;
  import cache_pkg::*;

  typedef enum {
    acc_fault,
    acc_hit,
    acc_miss,
    acc_write
  } access_t;

  localparam int unsigned cycles_per_request = 200;

  // pages and words used by the tests
  localparam logic [`MC_VTAG_W-1:0]     vtag_a   = 14'h0123;
  localparam logic [`MC_VTAG_W-1:0]     vtag_bad = 14'h0124;
  localparam logic [`MC_PAGE_IDX_W-1:0] page_a   = 8'h10;
  localparam logic [`MC_PTAG_W-1:0]     ptag_a0  = 14'h0200;
  localparam logic [`MC_PTAG_W-1:0]     ptag_a1  = 14'h0345;
  localparam logic [`MC_VTAG_W-1:0]     vtag_d   = 14'h0777;
  localparam logic [`MC_PAGE_IDX_W-1:0] page_d   = 8'h55;
  localparam logic [`MC_PTAG_W-1:0]     ptag_d   = 14'h0abc;

  logic                   CPU_CLK;
  logic                   RST;
  logic                   reset_req;
  cpu_req_t               cpu_req;
  cpu_rsp_t               cpu_rsp;
  logic                   busy;
  tlb_write_t             tlb_wr;
  mem_req_t               mem_req;
  mem_rsp_t               mem_rsp;
  int unsigned            cycle_cnt = 0;
  int unsigned            requests_issued = 0;
  int unsigned            mem_rsp_cyc;
  logic [`MC_DATA_W-1:0]  mem_words [logic [`MC_WADDR_W-1:0]];

  tb_clk_gen i_clk_gen (
    .reset_req (reset_req),
    .CPU_CLK   (CPU_CLK),
    .RST       (RST)
  );

  mmu_cache_top i_dut (
    .CPU_CLK (CPU_CLK),
    .RST     (RST),
    .cpu_req (cpu_req),
    .cpu_rsp (cpu_rsp),
    .busy    (busy),
    .tlb_wr  (tlb_wr),
    .mem_req (mem_req),
    .mem_rsp (mem_rsp)
  );

  always @(posedge CPU_CLK)
  begin
    cycle_cnt <= cycle_cnt + 1;
  end

  // --------------------------------------------------
  // memory model
  // --------------------------------------------------
  function automatic logic [`MC_DATA_W-1:0] model_word(input logic [`MC_WADDR_W-1:0] waddr);
    if (mem_words.exists(waddr))
    begin
      return mem_words[waddr];
    end
    return {2'b00, waddr} ^ 32'h5a5a_0000;
  endfunction

  initial
  begin : memory_model
    int unsigned             delay;
    logic                    pending;
    logic [`MC_WADDR_W-1:0]  rd_addr;
    delay = 0;
    pending = 1'b0;
    rd_addr = '0;
    mem_rsp = '0;
    mem_rsp_cyc = 0;
    void'($urandom(32'h9c96));
    forever
    begin
      @(negedge CPU_CLK);
      mem_rsp = '0;
      if (pending)
      begin
        delay = delay - 1;
        if (delay == 0)
        begin
          mem_rsp.valid = 1'b1;
          mem_rsp.rdata = model_word(rd_addr);
          mem_rsp_cyc = cycle_cnt;
          pending = 1'b0;
        end
      end
      if (mem_req.valid && mem_req.write)
      begin
        mem_words[mem_req.waddr] = mem_req.wdata;
      end
      else if (mem_req.valid)
      begin
        pending = 1'b1;
        rd_addr = mem_req.waddr;
        delay = 1 + ($urandom % 6);
      end
    end
  end

  // --------------------------------------------------
  // failure reporting and compare tasks
  // --------------------------------------------------
  task automatic stop_on_failure(input string reason);
    if (reason.len() > 0)
    begin
      $display("%s", reason);
    end
    $display("tests failed");
    $fatal(1, "stopping at the first error");
  endtask

  task automatic check_count(input string name, input int unsigned got,
                             input int unsigned exp);
    if (got != exp)
    begin
      $display("FAIL at %0d ns: %s is %0d, expected %0d", $time, name, got, exp);
      stop_on_failure("");
    end
  endtask

  task automatic check_rsp(input string name, input cpu_rsp_t got, input cpu_rsp_t exp,
                           input logic with_data);
    cpu_rsp_t got_cmp;
    got_cmp = got;
    if (!with_data)
    begin
      got_cmp.rdata = exp.rdata;
    end
    if (got_cmp !== exp)
    begin
      $display("FAIL at %0d ns: %s is %h, expected %h", $time, name, got, exp);
      stop_on_failure("");
    end
  endtask

  task automatic check_mem_req(input string name, input mem_req_t got, input mem_req_t exp);
    mem_req_t got_cmp;
    got_cmp = got;
    // read requests carry no data
    if (!exp.write)
    begin
      got_cmp.wdata = exp.wdata;
    end
    if (got_cmp !== exp)
    begin
      $display("FAIL at %0d ns: %s is %h, expected %h", $time, name, got, exp);
      stop_on_failure("");
    end
  endtask

  // --------------------------------------------------
  // stimulus helpers start and end on a falling edge
  // --------------------------------------------------
  function automatic logic [`MC_ADDR_W-1:0] make_vaddr(input logic [`MC_VTAG_W-1:0] vtag,
                                                       input logic [`MC_PAGE_IDX_W-1:0] page,
                                                       input logic [`MC_IDX_W-1:0] word);
    return {vtag, page, word, 2'b00};
  endfunction

  task automatic load_tlb(input logic [`MC_PAGE_IDX_W-1:0] idx,
                          input logic [`MC_VTAG_W-1:0] vtag,
                          input logic [`MC_PTAG_W-1:0] ptag);
    tlb_wr.valid = 1'b1;
    tlb_wr.idx = idx;
    tlb_wr.entry.vtag = vtag;
    tlb_wr.entry.ptag = ptag;
    @(negedge CPU_CLK);
    tlb_wr = '0;
  endtask

  task automatic apply_reset();
    reset_req = 1'b1;
    @(negedge CPU_CLK);
    reset_req = 1'b0;
    wait (RST == 1'b1);
    @(negedge CPU_CLK);
    check_count("busy after reset", busy, 0);
  endtask

  // one request with the expected outcome given by kind
  task automatic run_access(input access_t kind, input logic write,
                            input logic [`MC_ADDR_W-1:0] vaddr,
                            input logic [`MC_DATA_W-1:0] wdata,
                            input logic [`MC_PTAG_W-1:0] ptag);
    logic [`MC_WADDR_W-1:0]  waddr;
    cpu_rsp_t                exp_rsp;
    mem_req_t                exp_mreq;
    mem_req_t                got_mreq;
    int unsigned             start_cyc;
    int unsigned             mreq_lat;
    int unsigned             n_mem;
    int unsigned             n_busy;
    logic                    uses_mem;
    waddr = {ptag, vaddr[`MC_VTAG_LSB-1:`MC_IDX_LSB]};
    uses_mem = (kind == acc_miss) || (kind == acc_write);
    exp_mreq.valid = 1'b1;
    exp_mreq.write = write;
    exp_mreq.waddr = waddr;
    exp_mreq.wdata = wdata;
    got_mreq = '0;
    mreq_lat = 0;
    n_mem = 0;
    n_busy = 0;
    start_cyc = cycle_cnt;
    requests_issued = requests_issued + 1;
    cpu_req.valid = 1'b1;
    cpu_req.write = write;
    cpu_req.vaddr = vaddr;
    cpu_req.wdata = wdata;
    // collect memory traffic up to the response strobe
    do
    begin
      @(negedge CPU_CLK);
      cpu_req = '0;
      if (busy)
      begin
        n_busy = n_busy + 1;
      end
      if (mem_req.valid)
      begin
        n_mem = n_mem + 1;
        got_mreq = mem_req;
        mreq_lat = cycle_cnt - start_cyc;
      end
    end while (!cpu_rsp.valid);
    // memory model holds every earlier store by now
    exp_rsp.valid = 1'b1;
    exp_rsp.fault = (kind == acc_fault);
    exp_rsp.rdata = (kind == acc_fault) ? '0 : model_word(waddr);
    if (kind == acc_miss)
    begin
      check_count("cpu_rsp cycles after mem_rsp", cycle_cnt - mem_rsp_cyc, 1);
    end
    else
    begin
      check_count("cpu_rsp latency", cycle_cnt - start_cyc, 2);
    end
    check_count("busy at cpu_rsp", busy, 0);
    check_count("busy cycles", n_busy, cycle_cnt - start_cyc - 1);
    check_count("mem_req count", n_mem, uses_mem ? 1 : 0);
    if (uses_mem)
    begin
      check_count("mem_req latency", mreq_lat, 2);
      check_mem_req("mem_req", got_mreq, exp_mreq);
    end
    check_rsp("cpu_rsp", cpu_rsp, exp_rsp, kind != acc_write);
  endtask

  // --------------------------------------------------
  // directed tests
  // --------------------------------------------------
  task automatic test_fault();
    logic [`MC_ADDR_W-1:0] va;
    va = make_vaddr(vtag_a, page_a, 8'h04);
    $display("test: translation fault");
    run_access(acc_fault, 1'b0, va, '0, '0);
    load_tlb(page_a, vtag_bad, ptag_a0);
    run_access(acc_fault, 1'b0, va, '0, '0);
    run_access(acc_fault, 1'b1, va, 32'h1111_2222, '0);
  endtask

  task automatic test_read_miss();
    $display("test: read miss");
    load_tlb(page_a, vtag_a, ptag_a0);
    run_access(acc_miss, 1'b0, make_vaddr(vtag_a, page_a, 8'h04), '0, ptag_a0);
    run_access(acc_miss, 1'b0, make_vaddr(vtag_a, page_a, 8'h05), '0, ptag_a0);
  endtask

  task automatic test_read_hit();
    $display("test: read hit");
    run_access(acc_hit, 1'b0, make_vaddr(vtag_a, page_a, 8'h04), '0, ptag_a0);
    run_access(acc_hit, 1'b0, make_vaddr(vtag_a, page_a, 8'h05), '0, ptag_a0);
  endtask

  task automatic test_write();
    logic [`MC_ADDR_W-1:0] va_a;
    logic [`MC_ADDR_W-1:0] va_b;
    va_a = make_vaddr(vtag_a, page_a, 8'h04);
    va_b = make_vaddr(vtag_a, page_a, 8'h20);
    $display("test: write through");
    // line never read before so the store fills it
    run_access(acc_write, 1'b1, va_b, 32'hcafe_0001, ptag_a0);
    run_access(acc_hit, 1'b0, va_b, '0, ptag_a0);
    run_access(acc_write, 1'b1, va_a, 32'h0bad_f00d, ptag_a0);
    run_access(acc_hit, 1'b0, va_a, '0, ptag_a0);
  endtask

  task automatic test_reload();
    logic [`MC_ADDR_W-1:0] va;
    va = make_vaddr(vtag_a, page_a, 8'h04);
    $display("test: reloaded translation");
    load_tlb(page_a, vtag_a, ptag_a1);
    run_access(acc_miss, 1'b0, va, '0, ptag_a1);
    run_access(acc_hit, 1'b0, va, '0, ptag_a1);
  endtask

  task automatic test_conflict_reset();
    logic [`MC_ADDR_W-1:0] va_c;
    logic [`MC_ADDR_W-1:0] va_d;
    va_c = make_vaddr(vtag_a, page_a, 8'h30);
    va_d = make_vaddr(vtag_d, page_d, 8'h30);
    $display("test: index conflict and reset");
    load_tlb(page_d, vtag_d, ptag_d);
    repeat (2)
    begin
      run_access(acc_miss, 1'b0, va_c, '0, ptag_a1);
      run_access(acc_miss, 1'b0, va_d, '0, ptag_d);
    end
    apply_reset();
    run_access(acc_fault, 1'b0, make_vaddr(vtag_a, page_a, 8'h04), '0, '0);
    load_tlb(page_a, vtag_a, ptag_a0);
    // earlier store must have reached memory
    run_access(acc_miss, 1'b0, make_vaddr(vtag_a, page_a, 8'h20), '0, ptag_a0);
    run_access(acc_fault, 1'b0, va_d, '0, '0);
  endtask

  // budget grows with every issued request
  initial
  begin : watchdog
    forever
    begin
      @(posedge CPU_CLK);
      if (cycle_cnt > cycles_per_request * (requests_issued + 1))
      begin
        stop_on_failure("watchdog expired before the tests completed");
      end
    end
  end

  initial
  begin : main
    cpu_req = '0;
    tlb_wr = '0;
    reset_req = 1'b0;
    wait (RST == 1'b1);
    @(negedge CPU_CLK);
    test_fault();
    test_read_miss();
    test_read_hit();
    test_write();
    test_reload();
    test_conflict_reset();
    $display("all tests passed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== sim/mmu_cache_asserts.sv ====
/* concurrent protocol checks on the cache top level,
   bound into every mmu_cache_top instance */
`timescale 1ns/1ps
`default_nettype none

module mmu_cache_asserts (
  input wire                       CPU_CLK,
  input wire                       RST,
  input wire cache_pkg::cpu_req_t  cpu_req,
  input wire cache_pkg::cpu_rsp_t  cpu_rsp,
  input wire                       busy,
  input wire mmu_pkg::tlb_write_t  tlb_wr,
  input wire cache_pkg::mem_req_t  mem_req
);
  import mmu_pkg::*;
  import cache_pkg::*;

  // only one request in flight, no back-pressure
  no_req_while_busy: assert property (@(posedge CPU_CLK) disable iff (!RST)
    !(cpu_req.valid && busy))
    else $error("cpu_req strobed while busy");

  // TLB load and lookup share the table read port timing
  no_tlb_wr_with_req: assert property (@(posedge CPU_CLK) disable iff (!RST)
    !(tlb_wr.valid && cpu_req.valid))
    else $error("tlb_wr strobed together with cpu_req");

  rsp_single_cycle: assert property (@(posedge CPU_CLK) disable iff (!RST)
    cpu_rsp.valid |=> !cpu_rsp.valid)
    else $error("cpu_rsp valid held for more than one cycle");

  // synchronous reset, so outputs are quiet one edge later
  quiet_in_reset: assert property (@(posedge CPU_CLK)
    !RST |=> (!mem_req.valid && !cpu_rsp.valid))
    else $error("mem_req or cpu_rsp active during reset");

endmodule

bind mmu_cache_top mmu_cache_asserts i_asserts (
  .CPU_CLK (CPU_CLK),
  .RST     (RST),
  .cpu_req (cpu_req),
  .cpu_rsp (cpu_rsp),
  .busy    (busy),
  .tlb_wr  (tlb_wr),
  .mem_req (mem_req)
);

`default_nettype wire

// ==== sim/tb_clk_gen.sv ====
/* testbench clock, 40 ns period, and synchronous reset held low
   for 5 cycles at start and on each reset request */
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
  input  wire   reset_req,
  output logic  CPU_CLK,
  output logic  RST
);

  localparam int half_period = 20;
  localparam int reset_cycles = 5;

  initial
  begin
    CPU_CLK = 1'b0;
    forever #(half_period) CPU_CLK = ~CPU_CLK;
  end

  // reset changes on falling edges only
  initial
  begin
    RST = 1'b0;
    forever
    begin
      repeat (reset_cycles) @(negedge CPU_CLK);
      RST = 1'b1;
      @(posedge reset_req);
      RST = 1'b0;
    end
  end

endmodule

`default_nettype wire

// ==== source/mmu_cache_top.sv ====
/* cache top: TLB and line lookups in parallel on the request
   address, followed by the miss controller */
`timescale 1ns/1ps
`default_nettype none
`include "mmu_cache_consts.svh"

module mmu_cache_top (
  input  wire                       CPU_CLK,
  input  wire                       RST,
  input  wire cache_pkg::cpu_req_t  cpu_req,
  output cache_pkg::cpu_rsp_t       cpu_rsp,
  output logic                      busy,
  input  wire mmu_pkg::tlb_write_t  tlb_wr,
  output cache_pkg::mem_req_t       mem_req,
  input  wire cache_pkg::mem_rsp_t  mem_rsp
);
  import mmu_pkg::*;
  import cache_pkg::*;

  xlate_t                 xlate;
  cache_line_t            line;
  logic                   line_valid;
  logic                   fill_we;
  logic [`MC_IDX_W-1:0]   fill_idx;
  cache_line_t            fill_line;

  tlb_lookup i_tlb_lookup (
    .CPU_CLK (CPU_CLK),
    .RST     (RST),
    .vaddr   (cpu_req.vaddr),
    .tlb_wr  (tlb_wr),
    .xlate   (xlate)
  );

  line_lookup i_line_lookup (
    .CPU_CLK    (CPU_CLK),
    .RST        (RST),
    .vaddr      (cpu_req.vaddr),
    .line       (line),
    .line_valid (line_valid),
    .fill_we    (fill_we),
    .fill_idx   (fill_idx),
    .fill_line  (fill_line)
  );

  miss_ctrl i_miss_ctrl (
    .CPU_CLK    (CPU_CLK),
    .RST        (RST),
    .cpu_req    (cpu_req),
    .xlate      (xlate),
    .line       (line),
    .line_valid (line_valid),
    .fill_we    (fill_we),
    .fill_idx   (fill_idx),
    .fill_line  (fill_line),
    .mem_req    (mem_req),
    .mem_rsp    (mem_rsp),
    .cpu_rsp    (cpu_rsp),
    .busy       (busy)
  );

endmodule

`default_nettype wire

// ==== source/miss_ctrl.sv ====
/* hit/fault decision, memory sequencing, refill,
   write-through and cpu response */
`timescale 1ns/1ps
`default_nettype none
`include "mmu_cache_consts.svh"

module miss_ctrl (
  input  wire                          CPU_CLK,
  input  wire                          RST,
  input  wire cache_pkg::cpu_req_t     cpu_req,
  input  wire mmu_pkg::xlate_t         xlate,
  input  wire cache_pkg::cache_line_t  line,
  input  wire                          line_valid,
  output logic                         fill_we,
  output logic [`MC_IDX_W-1:0]         fill_idx,
  output cache_pkg::cache_line_t       fill_line,
  output cache_pkg::mem_req_t          mem_req,
  input  wire cache_pkg::mem_rsp_t     mem_rsp,
  output cache_pkg::cpu_rsp_t          cpu_rsp,
  output logic                         busy
);
  import cache_pkg::*;

  typedef enum logic [1:0] {
    S_IDLE,
    S_DECIDE,
    S_WAIT_MEM,
    S_RESPOND
  } state_t;

  state_t                  state;
  cpu_req_t                req_q;
  logic [`MC_PTAG_W-1:0]   ptag_q;
  logic                    rsp_fault_q;
  logic [`MC_DATA_W-1:0]   rsp_data_q;
  logic                    mem_valid_q;
  logic                    mem_write_q;
  logic [`MC_WADDR_W-1:0]  mem_waddr_q;
  logic [`MC_DATA_W-1:0]   mem_wdata_q;

  logic                    accept;
  logic                    fault;
  logic                    hit;
  logic [`MC_LTAG_W-1:0]   req_ltag;
  logic [`MC_LTAG_W-1:0]   fill_ltag;
  logic [`MC_WADDR_W-1:0]  phys_waddr;

  //--------------------------------------------------
  // decision, valid only in S_DECIDE
  //--------------------------------------------------
  // a request in S_RESPOND is taken too, busy is already low there
  assign accept = cpu_req.valid && ((state == S_IDLE) || (state == S_RESPOND));
  assign busy = (state == S_DECIDE) || (state == S_WAIT_MEM);

  always_comb
  begin
    fault = !xlate.hit;
    req_ltag = {xlate.ptag, req_q.vaddr[`MC_VTAG_LSB-1:`MC_PAGE_LSB]};
    hit = line_valid && (line.tag == req_ltag);
    phys_waddr = {xlate.ptag, req_q.vaddr[`MC_VTAG_LSB-1:`MC_IDX_LSB]};
    fill_ltag = {ptag_q, req_q.vaddr[`MC_VTAG_LSB-1:`MC_PAGE_LSB]};
  end

  // line write: store in decide, refill when memory answers
  always_comb
  begin
    fill_idx = req_q.vaddr[`MC_PAGE_LSB-1:`MC_IDX_LSB];
    if (state == S_DECIDE)
    begin
      fill_we = req_q.write && !fault;
      fill_line.tag = req_ltag;
      fill_line.data = req_q.wdata;
    end
    else
    begin
      fill_we = (state == S_WAIT_MEM) && mem_rsp.valid;
      fill_line.tag = fill_ltag;
      fill_line.data = mem_rsp.rdata;
    end
  end

  //--------------------------------------------------
  // state and strobes
  //--------------------------------------------------
  always_ff @(posedge CPU_CLK)
  begin
    if (!RST)
    begin
      state <= S_IDLE;
      mem_valid_q <= 1'b0;
    end
    else
    begin
      mem_valid_q <= 1'b0;
      case (state)
        S_IDLE, S_RESPOND:
        begin
          state <= accept ? S_DECIDE : S_IDLE;
        end
        S_DECIDE:
        begin
          if (fault || (!req_q.write && hit))
          begin
            state <= S_RESPOND;
          end
          else if (req_q.write)
          begin
            // write-through, posted
            state <= S_RESPOND;
            mem_valid_q <= 1'b1;
          end
          else
          begin
            state <= S_WAIT_MEM;
            mem_valid_q <= 1'b1;
          end
        end
        S_WAIT_MEM:
        begin
          if (mem_rsp.valid)
          begin
            state <= S_RESPOND;
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  // payload registers
  always_ff @(posedge CPU_CLK)
  begin
    if (accept)
    begin
      req_q <= cpu_req;
    end
    if (state == S_DECIDE)
    begin
      ptag_q <= xlate.ptag;
      mem_write_q <= req_q.write;
      mem_waddr_q <= phys_waddr;
      mem_wdata_q <= req_q.wdata;
      rsp_fault_q <= fault;
      if (fault)
      begin
        rsp_data_q <= '0;
      end
      else
      begin
        rsp_data_q <= req_q.write ? req_q.wdata : line.data;
      end
    end
    else if ((state == S_WAIT_MEM) && mem_rsp.valid)
    begin
      rsp_data_q <= mem_rsp.rdata;
    end
  end

  always_comb
  begin
    mem_req.valid = mem_valid_q;
    mem_req.write = mem_write_q;
    mem_req.waddr = mem_waddr_q;
    mem_req.wdata = mem_wdata_q;
    cpu_rsp.valid = (state == S_RESPOND);
    cpu_rsp.fault = rsp_fault_q;
    cpu_rsp.rdata = rsp_data_q;
  end

endmodule

`default_nettype wire

// ==== source/line_lookup.sv ====
/* cache line storage with per-line valid bits,
   read on every request address, written on fill or store */
`timescale 1ns/1ps
`default_nettype none
`include "mmu_cache_consts.svh"

module line_lookup (
  input  wire                          CPU_CLK,
  input  wire                          RST,
  input  wire [`MC_ADDR_W-1:0]         vaddr,
  output cache_pkg::cache_line_t       line,
  output logic                         line_valid,
  input  wire                          fill_we,
  input  wire [`MC_IDX_W-1:0]          fill_idx,
  input  wire cache_pkg::cache_line_t  fill_line
);
  import cache_pkg::*;

  logic [`MC_DEPTH-1:0]  line_vld;
  logic [`MC_IDX_W-1:0]  rd_idx;

  assign rd_idx = vaddr[`MC_PAGE_LSB-1:`MC_IDX_LSB];

  // tag and data together in one word
  lookup_ram #(
    .entry_t (cache_line_t),
    .depth   (`MC_DEPTH)
  ) i_line_ram (
    .CPU_CLK (CPU_CLK),
    .raddr   (rd_idx),
    .rdata   (line),
    .we      (fill_we),
    .waddr   (fill_idx),
    .wdata   (fill_line)
  );

  // valid bits never clear except on reset
  always_ff @(posedge CPU_CLK)
  begin
    if (!RST)
    begin
      line_vld <= '0;
      line_valid <= 1'b0;
    end
    else
    begin
      if (fill_we)
      begin
        line_vld[fill_idx] <= 1'b1;
      end
      line_valid <= line_vld[rd_idx];
    end
  end

endmodule

`default_nettype wire

// ==== source/tlb_lookup.sv ====
/* TLB storage with per-entry valid bits, virtual tag compare,
   translation result one cycle after the address */
`timescale 1ns/1ps
`default_nettype none
`include "mmu_cache_consts.svh"

module tlb_lookup (
  input  wire                       CPU_CLK,
  input  wire                       RST,
  input  wire [`MC_ADDR_W-1:0]      vaddr,
  input  wire mmu_pkg::tlb_write_t  tlb_wr,
  output mmu_pkg::xlate_t           xlate
);
  import mmu_pkg::*;

  logic [`MC_DEPTH-1:0]     entry_valid;
  logic                     valid_rd;
  logic [`MC_VTAG_W-1:0]    vtag_q;
  tlb_entry_t               entry_rd;

  lookup_ram #(
    .entry_t (tlb_entry_t),
    .depth   (`MC_DEPTH)
  ) i_tlb_ram (
    .CPU_CLK (CPU_CLK),
    .raddr   (vaddr[`MC_VTAG_LSB-1:`MC_PAGE_LSB]),
    .rdata   (entry_rd),
    .we      (tlb_wr.valid),
    .waddr   (tlb_wr.idx),
    .wdata   (tlb_wr.entry)
  );

  // valid bits, read alongside the ram
  always_ff @(posedge CPU_CLK)
  begin
    if (!RST)
    begin
      entry_valid <= '0;
      valid_rd <= 1'b0;
    end
    else
    begin
      if (tlb_wr.valid)
      begin
        entry_valid[tlb_wr.idx] <= 1'b1;
      end
      valid_rd <= entry_valid[vaddr[`MC_VTAG_LSB-1:`MC_PAGE_LSB]];
    end
  end

  // requested virtual tag, aligned with the ram output
  always_ff @(posedge CPU_CLK)
  begin
    vtag_q <= vaddr[`MC_ADDR_W-1:`MC_VTAG_LSB];
  end

  always_comb
  begin
    xlate.hit = valid_rd && (entry_rd.vtag == vtag_q);
    xlate.ptag = entry_rd.ptag;
  end

endmodule

`default_nettype wire

// ==== source/lookup_ram.sv ====
/* inferred RAM, registered read port and one write port,
   word type given as a type parameter */
`timescale 1ns/1ps
`default_nettype none

module lookup_ram #(
  parameter type entry_t = logic [31:0],
  parameter int depth = 256,
  localparam int addr_w = $clog2(depth)
) (
  input  wire               CPU_CLK,
  input  wire [addr_w-1:0]  raddr,
  output entry_t            rdata,
  input  wire               we,
  input  wire [addr_w-1:0]  waddr,
  input  wire entry_t       wdata
);

  entry_t mem [depth];

  // read returns the old word when raddr equals waddr
  always_ff @(posedge CPU_CLK)
  begin
    if (we)
    begin
      mem[waddr] <= wdata;
    end
    rdata <= mem[raddr];
  end

endmodule

`default_nettype wire

// ==== source/cache_pkg.sv ====
/* cpu and memory request/response types, stored cache line type */
`default_nettype none
`include "mmu_cache_consts.svh"

package cache_pkg;

  //--------------------------------------------------
  // cpu side
  //--------------------------------------------------
  typedef struct packed {
    logic                   valid;
    logic                   write;
    logic [`MC_ADDR_W-1:0]  vaddr;
    logic [`MC_DATA_W-1:0]  wdata;
  } cpu_req_t;

  typedef struct packed {
    logic                   valid;
    logic                   fault;
    logic [`MC_DATA_W-1:0]  rdata;
  } cpu_rsp_t;

  // line tag is physical address [31:10]
  typedef struct packed {
    logic [`MC_LTAG_W-1:0]  tag;
    logic [`MC_DATA_W-1:0]  data;
  } cache_line_t;

  //--------------------------------------------------
  // memory side
  //--------------------------------------------------
  typedef struct packed {
    logic                   valid;
    logic                   write;
    logic [`MC_WADDR_W-1:0] waddr;
    logic [`MC_DATA_W-1:0]  wdata;
  } mem_req_t;

  // writes are posted, only reads get one of these
  typedef struct packed {
    logic                   valid;
    logic [`MC_DATA_W-1:0]  rdata;
  } mem_rsp_t;

endpackage

`default_nettype wire

// ==== source/mmu_pkg.sv ====
/* translation types: TLB entry, TLB write strobe, translation result */
`default_nettype none
`include "mmu_cache_consts.svh"

package mmu_pkg;

  // one stored translation
  typedef struct packed {
    logic [`MC_VTAG_W-1:0]     vtag;
    logic [`MC_PTAG_W-1:0]     ptag;
  } tlb_entry_t;

  // software load of one entry, single-cycle strobe
  typedef struct packed {
    logic                      valid;
    logic [`MC_PAGE_IDX_W-1:0] idx;
    tlb_entry_t                entry;
  } tlb_write_t;

  // translation result
  // hit means entry valid and virtual tag equal
  typedef struct packed {
    logic                      hit;
    logic [`MC_PTAG_W-1:0]     ptag;
  } xlate_t;

endpackage

`default_nettype wire

// ==== source/mmu_cache_consts.svh ====
/* address field widths, table depth and derived field positions
   shared by the cache, the TLB and their packages */
`ifndef MMU_CACHE_CONSTS_SVH
`define MMU_CACHE_CONSTS_SVH

// bus widths
`define MC_ADDR_W      32
`define MC_DATA_W      32
`define MC_WADDR_W     (`MC_ADDR_W - 2)

// virtual address fields
`define MC_IDX_W       8
`define MC_PAGE_IDX_W  8
`define MC_VTAG_W      14
`define MC_IDX_LSB     2
`define MC_PAGE_LSB    (`MC_IDX_LSB + `MC_IDX_W)
`define MC_VTAG_LSB    (`MC_PAGE_LSB + `MC_PAGE_IDX_W)

// physical side
`define MC_PTAG_W      14
`define MC_LTAG_W      22

// entries per table
`define MC_DEPTH       256

`endif
